/* hw/cnn_pkg.sv */
package cnn_pkg;

	// Half-precision value as it sits in the feature-map RAM
	// sign [15], exponent [14:10], mantissa [9:0]
	typedef logic [15:0] fp16_t;

	// Layer command codes driven by the host
	// Codes not listed here leave the controller idle
	typedef enum logic [3:0] {
		LAYER_INIT   = 4'd0,
		LAYER_POOL   = 4'd2,
		LAYER_FINISH = 4'd9
	} layer_type_e;

	// Feature-map side length, sides up to 16
	localparam int FM_SIZE_W = 5;

	// Pool window size field, window of 2 or 3
	localparam int WIN_W = 2;

	// Layer number, compared against the stored one to detect a new layer
	localparam int LAYER_NUM_W = 4;

	// Channel lanes carried by one RAM word
	localparam int DEF_PARA_C = 4;

	// Address width of one RAM half
	// 256 words hold a full 16x16 map
	localparam int DEF_HALF_ADDR_W = 8;

endpackage

/* hw/fm_ram.sv */
`timescale 1ns/1ps

module fm_ram import cnn_pkg::*; #(
	parameter int PARA_C      = DEF_PARA_C,
	parameter int HALF_ADDR_W = DEF_HALF_ADDR_W
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    swap_i,
	input  logic                    ld_wr_en_i,
	input  logic [HALF_ADDR_W-1:0]  ld_wr_addr_i,
	input  fp16_t [PARA_C-1:0]      ld_wr_data_i,
	input  logic                    pool_rd_en_i,
	input  logic [HALF_ADDR_W-1:0]  pool_rd_addr_i,
	input  logic                    pool_wr_en_i,
	input  logic [HALF_ADDR_W-1:0]  pool_wr_addr_i,
	input  fp16_t [PARA_C-1:0]      pool_wr_data_i,
	input  logic                    ext_rd_en_i,
	input  logic [HALF_ADDR_W-1:0]  ext_rd_addr_i,
	output fp16_t [PARA_C-1:0]      pool_rd_data_o,
	output logic                    pool_rd_valid_o,
	output fp16_t [PARA_C-1:0]      ext_rd_data_o
);

	localparam int DEPTH = 2 ** (HALF_ADDR_W + 1);

	// Both halves in one array, the top address bit picks the half
	fp16_t [PARA_C-1:0] mem [DEPTH];

	logic                   wr_en;
	logic [HALF_ADDR_W:0]   wr_phys;
	fp16_t [PARA_C-1:0]     wr_word;

	// Single write port
	// Pool results go to the inactive half, loads to the active one
	always_comb begin
		wr_en = pool_wr_en_i | ld_wr_en_i;
		if (pool_wr_en_i) begin
			wr_phys = {~swap_i, pool_wr_addr_i};
			wr_word = pool_wr_data_i;
		end else begin
			wr_phys = {swap_i, ld_wr_addr_i};
			wr_word = ld_wr_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_phys] <= wr_word;
		end
	end

	// Both read ports look at the active half, one cycle of latency
	always_ff @(posedge clk) begin
		if (pool_rd_en_i) begin
			pool_rd_data_o <= mem[{swap_i, pool_rd_addr_i}];
		end
		if (ext_rd_en_i) begin
			ext_rd_data_o <= mem[{swap_i, ext_rd_addr_i}];
		end
	end

	// Valid flag follows the pool read enable by one cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pool_rd_valid_o <= 1'b0;
		end else begin
			pool_rd_valid_o <= pool_rd_en_i;
		end
	end

endmodule

/* hw/max_pool_lane.sv */
`timescale 1ns/1ps

module max_pool_lane import cnn_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  fp16_t              data_i,
	input  logic               valid_i,
	input  logic [2*WIN_W-1:0] data_num_i,
	output logic               result_ready_o,
	output fp16_t              result_o
);

	logic [2*WIN_W-1:0] count;
	logic               take;

	// Sign-magnitude to unsigned order
	// negatives are inverted so that larger magnitude ranks lower
	// positives get the sign bit set so they rank above every negative
	function automatic logic [15:0] order_key(input fp16_t v);
		return v[15] ? ~v : {1'b1, v[14:0]};
	endfunction

	// First word of a window always loads
	// Later ones only on a strictly larger key, ties keep the earlier value
	assign take = valid_i &&
		(count == '0 || order_key(data_i) > order_key(result_o));

	// Window counter and ready flag
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count          <= '0;
			result_ready_o <= 1'b0;
		end else if (start_i) begin
			count          <= '0;
			result_ready_o <= 1'b0;
		end else if (valid_i) begin
			count <= count + 1'b1;
			// Ready is visible the cycle after the last word
			if (count + 1'b1 == data_num_i) begin
				result_ready_o <= 1'b1;
			end
		end
	end

	// Running maximum
	always_ff @(posedge clk) begin
		if (take && !start_i) begin
			result_o <= data_i;
		end
	end

endmodule

/* hw/pool_layer_ctrl.sv */
`timescale 1ns/1ps

module pool_layer_ctrl import cnn_pkg::*; #(
	parameter int PARA_C      = DEF_PARA_C,
	parameter int HALF_ADDR_W = DEF_HALF_ADDR_W
) (
	input  logic                   clk,
	input  logic                   rst,
	input  layer_type_e            layer_type_i,
	input  logic [LAYER_NUM_W-1:0] layer_num_i,
	input  logic [FM_SIZE_W-1:0]   fm_size_i,
	input  logic [WIN_W-1:0]       pool_win_size_i,
	input  logic                   init_done_i,
	input  logic                   lane_ready_i,
	output logic                   init_fm_ram_ready_o,
	output logic                   layer_ready_o,
	output logic                   swap_o,
	output logic                   pool_rd_en_o,
	output logic [HALF_ADDR_W-1:0] pool_rd_addr_o,
	output logic                   pool_wr_en_o,
	output logic [HALF_ADDR_W-1:0] pool_wr_addr_o,
	output logic                   win_start_o,
	output logic [2*WIN_W-1:0]     win_len_o
);

	// Each word needs a channel, and a half must fit the largest map
	if (PARA_C < 1 || HALF_ADDR_W < 2 * (FM_SIZE_W - 1)) begin : g_bad_cfg
		$error("pool_layer_ctrl: PARA_C or HALF_ADDR_W out of range");
	end

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_READ,
		S_WAIT
	} state_e;

	state_e                 state;
	logic [LAYER_NUM_W-1:0] cur_layer_num;
	logic                   swap;

	// Top left corner of the current window in the source map
	logic [FM_SIZE_W-1:0]   row_base;
	logic [FM_SIZE_W-1:0]   col_base;
	// Offset inside the window
	logic [WIN_W-1:0]       kx;
	logic [WIN_W-1:0]       ky;
	// Output pixels come out row-major, so the write address just counts
	logic [HALF_ADDR_W-1:0] wr_addr;

	logic [FM_SIZE_W-1:0]   src_row;
	logic [FM_SIZE_W-1:0]   src_col;
	logic                   last_k;
	logic                   last_col;
	logic                   last_row;

	assign src_row = row_base + kx;
	assign src_col = col_base + ky;
	assign last_k  = (kx == pool_win_size_i - 1'b1) && (ky == pool_win_size_i - 1'b1);

	// No room for another window to the right or below
	assign last_col = int'(col_base) + 2 * int'(pool_win_size_i) > int'(fm_size_i);
	assign last_row = int'(row_base) + 2 * int'(pool_win_size_i) > int'(fm_size_i);

	assign swap_o         = swap;
	assign win_start_o    = (state == S_START);
	assign pool_rd_en_o   = (state == S_READ);
	assign pool_rd_addr_o = HALF_ADDR_W'(src_row * fm_size_i + src_col);
	// Write as soon as lane 0 has its maximum, all lanes run in lockstep
	assign pool_wr_en_o   = (state == S_WAIT) && lane_ready_i;
	assign pool_wr_addr_o = wr_addr;
	assign win_len_o      = {{WIN_W{1'b0}}, pool_win_size_i} * {{WIN_W{1'b0}}, pool_win_size_i};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state               <= S_IDLE;
			cur_layer_num       <= '0;
			init_fm_ram_ready_o <= 1'b0;
			layer_ready_o       <= 1'b0;
			swap                <= 1'b0;
			row_base            <= '0;
			col_base            <= '0;
			kx                  <= '0;
			ky                  <= '0;
			wr_addr             <= '0;
		end else if (layer_type_i == LAYER_FINISH) begin
			// Back to the post-reset state, ready for a fresh init
			state               <= S_IDLE;
			cur_layer_num       <= '0;
			init_fm_ram_ready_o <= 1'b0;
			layer_ready_o       <= 1'b0;
			swap                <= 1'b0;
		end else if (layer_type_i == LAYER_INIT) begin
			if (!layer_ready_o) begin
				if (init_done_i) begin
					init_fm_ram_ready_o <= 1'b1;
				end
				// Ready for layers one edge after the RAM is ready
				if (init_fm_ram_ready_o) begin
					layer_ready_o <= 1'b1;
				end
			end
		end else if (layer_type_i == LAYER_POOL && init_fm_ram_ready_o) begin
			case (state)
				S_IDLE: begin
					// New layer number starts a layer
					if (layer_num_i != cur_layer_num) begin
						cur_layer_num <= layer_num_i;
						layer_ready_o <= 1'b0;
						row_base      <= '0;
						col_base      <= '0;
						wr_addr       <= '0;
						state         <= S_START;
					end
				end
				S_START: begin
					// Lanes clear on this edge
					kx    <= '0;
					ky    <= '0;
					state <= S_READ;
				end
				S_READ: begin
					// Walk the window row by row, win^2 reads in a row
					if (ky == pool_win_size_i - 1'b1) begin
						ky <= '0;
						kx <= kx + 1'b1;
					end else begin
						ky <= ky + 1'b1;
					end
					if (last_k) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (lane_ready_i) begin
						wr_addr <= wr_addr + 1'b1;
						if (!last_col) begin
							col_base <= col_base + pool_win_size_i;
							state    <= S_START;
						end else if (!last_row) begin
							col_base <= '0;
							row_base <= row_base + pool_win_size_i;
							state    <= S_START;
						end else begin
							// Layer done, result half becomes the source
							swap          <= ~swap;
							layer_ready_o <= 1'b1;
							state         <= S_IDLE;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

/* hw/cnn_layer_top.sv */
`timescale 1ns/1ps

module cnn_layer_top import cnn_pkg::*; #(
	parameter int PARA_C      = DEF_PARA_C,
	parameter int HALF_ADDR_W = DEF_HALF_ADDR_W
) (
	input  logic                   clk,
	input  logic                   rst,
	input  layer_type_e            layer_type_i,
	input  logic [LAYER_NUM_W-1:0] layer_num_i,
	input  logic [FM_SIZE_W-1:0]   fm_size_i,
	input  logic [WIN_W-1:0]       pool_win_size_i,
	input  logic                   fm_wr_en_i,
	input  logic [HALF_ADDR_W-1:0] fm_wr_addr_i,
	input  fp16_t [PARA_C-1:0]     fm_wr_data_i,
	input  logic                   init_done_i,
	input  logic                   rd_en_i,
	input  logic [HALF_ADDR_W-1:0] rd_addr_i,
	output logic                   init_fm_ram_ready_o,
	output logic                   layer_ready_o,
	output fp16_t [PARA_C-1:0]     rd_data_o
);

	logic                   swap;
	logic                   pool_rd_en;
	logic [HALF_ADDR_W-1:0] pool_rd_addr;
	logic                   pool_wr_en;
	logic [HALF_ADDR_W-1:0] pool_wr_addr;
	logic                   win_start;
	logic [2*WIN_W-1:0]     win_len;

	// RAM read side into the lanes, lane results back to the RAM
	fp16_t [PARA_C-1:0]     pool_rd_data;
	logic                   pool_rd_valid;
	fp16_t [PARA_C-1:0]     pool_wr_data;
	logic [PARA_C-1:0]      lane_ready;

	pool_layer_ctrl #(
		.PARA_C      (PARA_C),
		.HALF_ADDR_W (HALF_ADDR_W)
	) u_ctrl (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type_i),
		.layer_num_i         (layer_num_i),
		.fm_size_i           (fm_size_i),
		.pool_win_size_i     (pool_win_size_i),
		.init_done_i         (init_done_i),
		.lane_ready_i        (lane_ready[0]),
		.init_fm_ram_ready_o (init_fm_ram_ready_o),
		.layer_ready_o       (layer_ready_o),
		.swap_o              (swap),
		.pool_rd_en_o        (pool_rd_en),
		.pool_rd_addr_o      (pool_rd_addr),
		.pool_wr_en_o        (pool_wr_en),
		.pool_wr_addr_o      (pool_wr_addr),
		.win_start_o         (win_start),
		.win_len_o           (win_len)
	);

	fm_ram #(
		.PARA_C      (PARA_C),
		.HALF_ADDR_W (HALF_ADDR_W)
	) u_fm_ram (
		.clk             (clk),
		.rst             (rst),
		.swap_i          (swap),
		.ld_wr_en_i      (fm_wr_en_i),
		.ld_wr_addr_i    (fm_wr_addr_i),
		.ld_wr_data_i    (fm_wr_data_i),
		.pool_rd_en_i    (pool_rd_en),
		.pool_rd_addr_i  (pool_rd_addr),
		.pool_wr_en_i    (pool_wr_en),
		.pool_wr_addr_i  (pool_wr_addr),
		.pool_wr_data_i  (pool_wr_data),
		.ext_rd_en_i     (rd_en_i),
		.ext_rd_addr_i   (rd_addr_i),
		.pool_rd_data_o  (pool_rd_data),
		.pool_rd_valid_o (pool_rd_valid),
		.ext_rd_data_o   (rd_data_o)
	);

	// One lane per channel of the word
	for (genvar i = 0; i < PARA_C; i++) begin : g_lane
		max_pool_lane u_lane (
			.clk            (clk),
			.rst            (rst),
			.start_i        (win_start),
			.data_i         (pool_rd_data[i]),
			.valid_i        (pool_rd_valid),
			.data_num_i     (win_len),
			.result_ready_o (lane_ready[i]),
			.result_o       (pool_wr_data[i])
		);
	end

endmodule

/* bench/cnn_layer_assertions.sv */
`timescale 1ns/1ps

module cnn_layer_assertions (
	input logic clk,
	input logic rst,
	input logic pool_rd_en_i,
	input logic pool_wr_en_i,
	input logic layer_ready_i,
	input logic init_fm_ram_ready_i
);

	// Number of failed checks
	int fail_count = 0;

	// No result write right after a read
	// The last word of a window is still on its way to the lanes
	rd_wr_separated: assert property (
		@(posedge clk) disable iff (!rst)
		pool_rd_en_i |=> !pool_wr_en_i
	) else begin
		$error("pool write directly after a pool read");
		fail_count++;
	end

	// Layers only run on an initialized RAM
	ready_needs_init: assert property (
		@(posedge clk) disable iff (!rst)
		layer_ready_i |-> init_fm_ram_ready_i
	) else begin
		$error("layer_ready_o high while init_fm_ram_ready_o low");
		fail_count++;
	end

	// One write per output pixel
	wr_single_cycle: assert property (
		@(posedge clk) disable iff (!rst)
		pool_wr_en_i |=> !pool_wr_en_i
	) else begin
		$error("pool_wr_en_o held for more than one cycle");
		fail_count++;
	end

endmodule

/* bench/cnn_layer_tb.sv */
`timescale 1ns/1ps

module cnn_layer_tb import cnn_pkg::*; ();

	localparam int PARA_C      = DEF_PARA_C;
	localparam int HALF_ADDR_W = DEF_HALF_ADDR_W;
	// Cycle budget, doubled for the timeout
	localparam int LOAD_WORDS  = 64 + 4;
	localparam int WIN_READS   = 16 * 4 + 1 * 9 + 1 * 4;
	localparam int WIN_WRITES  = 16 + 1 + 1;
	localparam int READBACKS   = 64 + 16 + 1 + 1 + 1 + 1;
	localparam int TIMEOUT_CYCLES =
		2 * (8 + LOAD_WORDS + WIN_READS + 3 * WIN_WRITES + 2 * READBACKS + 20);

	typedef fp16_t [PARA_C-1:0] word_t;

	logic                   clk;
	logic                   rst;
	layer_type_e            layer_type_i;
	logic [LAYER_NUM_W-1:0] layer_num_i;
	logic [FM_SIZE_W-1:0]   fm_size_i;
	logic [WIN_W-1:0]       pool_win_size_i;
	logic                   fm_wr_en_i;
	logic [HALF_ADDR_W-1:0] fm_wr_addr_i;
	word_t                  fm_wr_data_i;
	logic                   init_done_i;
	logic                   rd_en_i;
	logic [HALF_ADDR_W-1:0] rd_addr_i;
	logic                   init_fm_ram_ready_o;
	logic                   layer_ready_o;
	word_t                  rd_data_o;

	// Reference copy of both RAM halves and the active half
	word_t       model_half [2][2**HALF_ADDR_W];
	logic        model_swap;
	logic [15:0] lfsr_q;
	int          fp16_errors;
	int          flag_errors;
	int          cycle_count;

	cnn_layer_top #(
		.PARA_C      (PARA_C),
		.HALF_ADDR_W (HALF_ADDR_W)
	) UUT (
		.clk                 (clk),
		.rst                 (rst),
		.layer_type_i        (layer_type_i),
		.layer_num_i         (layer_num_i),
		.fm_size_i           (fm_size_i),
		.pool_win_size_i     (pool_win_size_i),
		.fm_wr_en_i          (fm_wr_en_i),
		.fm_wr_addr_i        (fm_wr_addr_i),
		.fm_wr_data_i        (fm_wr_data_i),
		.init_done_i         (init_done_i),
		.rd_en_i             (rd_en_i),
		.rd_addr_i           (rd_addr_i),
		.init_fm_ram_ready_o (init_fm_ram_ready_o),
		.layer_ready_o       (layer_ready_o),
		.rd_data_o           (rd_data_o)
	);

	// Handshake checks on the controller
	bind pool_layer_ctrl cnn_layer_assertions u_handshake_checks (
		.clk                   (clk),
		.rst                   (rst),
		.pool_rd_en_i          (pool_rd_en_o),
		.pool_wr_en_i          (pool_wr_en_o),
		.layer_ready_i         (layer_ready_o),
		.init_fm_ram_ready_i   (init_fm_ram_ready_o)
	);

	always #20 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: no layer_ready or init handshake after %0d cycles", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Taps 16 14 13 11, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	// Exponent kept below all ones, so no NaN or infinity
	function automatic fp16_t rand_fp16();
		fp16_t v;
		for (int i = 0; i < 16; i++) begin
			v[i] = lfsr_bit();
		end
		if (v[14:10] == 5'h1f) begin
			v[14:10] = 5'h1e;
		end
		return v;
	endfunction

	// Sign-magnitude ordering
	// Any positive ranks above any negative, so +0 above -0
	// Among negatives the smaller magnitude wins
	function automatic logic fp16_above(input fp16_t a, input fp16_t b);
		logic res;
		if (a[15] != b[15]) begin
			res = !a[15];
		end else if (a[15]) begin
			res = a[14:0] < b[14:0];
		end else begin
			res = a[14:0] > b[14:0];
		end
		return res;
	endfunction

	task automatic check_fp16(input string name, input fp16_t exp_v, input fp16_t act_v);
		if (exp_v !== act_v) begin
			fp16_errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (exp_v !== act_v) begin
			flag_errors++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic load_word(input int addr, input word_t w);
		@(posedge clk);
		fm_wr_en_i   <= 1'b1;
		fm_wr_addr_i <= HALF_ADDR_W'(addr);
		fm_wr_data_i <= w;
		model_half[model_swap][addr] = w;
	endtask

	task automatic end_load();
		@(posedge clk);
		fm_wr_en_i <= 1'b0;
	endtask

	// One readback, data valid one cycle after rd_en_i
	task automatic read_check(input int addr);
		@(posedge clk);
		rd_en_i   <= 1'b1;
		rd_addr_i <= HALF_ADDR_W'(addr);
		@(posedge clk);
		rd_en_i <= 1'b0;
		@(negedge clk);
		for (int c = 0; c < PARA_C; c++) begin
			check_fp16($sformatf("rd_data_o[%0d] addr %0d", c, addr),
				model_half[model_swap][addr][c], rd_data_o[c]);
		end
	endtask

	// Window scan in read order, first word loads, strict greater replaces
	task automatic pool_model(input int s, input int w);
		int    o;
		int    base;
		fp16_t best;
		fp16_t v;
		o = s / w;
		for (int ox = 0; ox < o; ox++) begin
			for (int oy = 0; oy < o; oy++) begin
				base = ox * w * s + oy * w;
				for (int c = 0; c < PARA_C; c++) begin
					best = model_half[model_swap][base][c];
					for (int kx = 0; kx < w; kx++) begin
						for (int ky = 0; ky < w; ky++) begin
							v = model_half[model_swap][base + kx * s + ky][c];
							if (fp16_above(v, best)) begin
								best = v;
							end
						end
					end
					model_half[~model_swap][ox * o + oy][c] = best;
				end
			end
		end
		model_swap = ~model_swap;
	endtask

	// Start a pool layer and wait for the ready drop and rise
	task automatic run_pool_layer(input int num, input int s, input int w);
		@(posedge clk);
		layer_type_i    <= LAYER_POOL;
		layer_num_i     <= LAYER_NUM_W'(num);
		fm_size_i       <= FM_SIZE_W'(s);
		pool_win_size_i <= WIN_W'(w);
		@(negedge clk);
		while (layer_ready_o) begin
			@(negedge clk);
		end
		while (!layer_ready_o) begin
			@(negedge clk);
		end
		pool_model(s, w);
	endtask

	initial begin
		word_t w;
		clk             = 1'b0;
		rst             = 1'b0;
		layer_type_i    = LAYER_INIT;
		layer_num_i     = '0;
		fm_size_i       = '0;
		pool_win_size_i = '0;
		fm_wr_en_i      = 1'b0;
		fm_wr_addr_i    = '0;
		fm_wr_data_i    = '0;
		init_done_i     = 1'b0;
		rd_en_i         = 1'b0;
		rd_addr_i       = '0;
		model_swap      = 1'b0;
		lfsr_q          = 16'd54;
		fp16_errors     = 0;
		flag_errors     = 0;
		cycle_count     = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_flag("init_fm_ram_ready_o", 1'b0, init_fm_ram_ready_o);
		check_flag("layer_ready_o", 1'b0, layer_ready_o);

		// 8x8 random map, then init handshake
		for (int a = 0; a < 64; a++) begin
			for (int c = 0; c < PARA_C; c++) begin
				w[c] = rand_fp16();
			end
			load_word(a, w);
		end
		end_load();
		init_done_i <= 1'b1;
		while (!layer_ready_o) begin
			@(negedge clk);
		end
		@(posedge clk);
		init_done_i <= 1'b0;
		@(negedge clk);
		check_flag("init_fm_ram_ready_o", 1'b1, init_fm_ram_ready_o);
		check_flag("layer_ready_o", 1'b1, layer_ready_o);
		for (int a = 0; a < 64; a++) begin
			read_check(a);
		end

		// 2x2 pool to 4x4, then chained 3x3 pool to 1x1
		run_pool_layer(1, 8, 2);
		for (int a = 0; a < 16; a++) begin
			read_check(a);
		end
		run_pool_layer(2, 4, 3);
		read_check(0);

		// Directed 2x2 window, lanes mix -0, +0 and negatives
		@(posedge clk);
		layer_type_i <= LAYER_INIT;
		load_word(0, {16'h8000, 16'h0000, 16'hc000, 16'h8000});
		load_word(1, {16'hbc00, 16'h8000, 16'hb800, 16'h0000});
		load_word(2, {16'h8000, 16'h0000, 16'hbc00, 16'hbc00});
		load_word(3, {16'hc000, 16'h8000, 16'hc200, 16'hc000});
		end_load();
		run_pool_layer(3, 2, 2);
		read_check(0);

		// Same layer number again must not restart
		@(posedge clk);
		layer_type_i <= LAYER_INIT;
		@(posedge clk);
		layer_type_i <= LAYER_POOL;
		repeat (10) begin
			@(negedge clk);
			check_flag("layer_ready_o", 1'b1, layer_ready_o);
		end
		read_check(0);

		// Finish clears both ready outputs
		@(posedge clk);
		layer_type_i <= LAYER_FINISH;
		@(posedge clk);
		@(negedge clk);
		check_flag("init_fm_ram_ready_o", 1'b0, init_fm_ram_ready_o);
		check_flag("layer_ready_o", 1'b0, layer_ready_o);

		// Finish also returns readback to the first half
		model_swap = 1'b0;
		read_check(0);

		$display("errors: fp16 mismatches %0d, flag mismatches %0d, assertion failures %0d",
			fp16_errors, flag_errors, UUT.u_ctrl.u_handshake_checks.fail_count);
		if (fp16_errors == 0 && flag_errors == 0 &&
			UUT.u_ctrl.u_handshake_checks.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* project.f */
hw/cnn_pkg.sv
hw/fm_ram.sv
hw/max_pool_lane.sv
hw/pool_layer_ctrl.sv
hw/cnn_layer_top.sv
bench/cnn_layer_assertions.sv
bench/cnn_layer_tb.sv

/* Bender.yml */
package:
  name: cnn_pool_layer

sources:
  - hw/cnn_pkg.sv
  - hw/fm_ram.sv
  - hw/max_pool_lane.sv
  - hw/pool_layer_ctrl.sv
  - hw/cnn_layer_top.sv
  - target: test
    files:
      - bench/cnn_layer_assertions.sv
      - bench/cnn_layer_tb.sv
